// ==== src/loader_pkg.sv ====
// program loader shared definitions
// bus and register sizes, entry geometry, register map and bus states
`default_nettype none

package loader_pkg;

    // host bus and register file
    localparam int DATA_W       = 32;
    localparam int BUS_ADDR_W   = 5;
    // byte address bits below this select a byte inside a register
    localparam int REG_ADDR_LSB = 2;
    localparam int REG_NUM      = 8;
    localparam int REG_IDX_W    = 3;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // memory entry geometry
    localparam int ENTRY_W         = 128;
    localparam int WORDS_PER_ENTRY = 4;
    localparam int WORD_CNT_W      = 2;
    // only the low bits of the address register reach the memory
    localparam int MEM_ADDR_W      = 16;

    // word queue between register writes and the packer
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = 3;

    // register map, indices 6 and 7 are plain storage
    typedef enum logic [REG_IDX_W-1:0] {
        REG_PUSH_FULL = 3'd0,
        REG_MEM_ADDR  = 3'd1,
        REG_PROG_SIZE = 3'd2,
        REG_ENTRY_CNT = 3'd3,
        REG_EMPTY     = 3'd4,
        REG_POP_CNT   = 3'd5
    } reg_offset_e;

    // write channel states, one transfer in flight
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ACCEPT,
        WR_RESP
    } wr_state_e;

    // read channel states
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ACCEPT,
        RD_DATA
    } rd_state_e;

endpackage

`default_nettype wire

// ==== src/axil_slave_ctrl.sv ====
// axi4-lite slave channel control for the loader registers
// turns bus transfers into single-cycle register write and read strobes
`default_nettype none
`timescale 1ns/1ps

module axil_slave_ctrl (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    // write address and data channels
    input  wire logic [loader_pkg::BUS_ADDR_W-1:0]   awaddr,
    input  wire logic                                awvalid,
    output logic                                     awready,
    input  wire logic [loader_pkg::DATA_W-1:0]       wdata,
    input  wire logic                                wvalid,
    output logic                                     wready,
    // write response channel
    output logic                                     bvalid,
    output logic [1:0]                               bresp,
    input  wire logic                                bready,
    // read address and data channels
    input  wire logic [loader_pkg::BUS_ADDR_W-1:0]   araddr,
    input  wire logic                                arvalid,
    output logic                                     arready,
    output logic                                     rvalid,
    output logic [loader_pkg::DATA_W-1:0]            rdata,
    output logic [1:0]                               rresp,
    input  wire logic                                rready,
    // register file side
    output logic                                     reg_wr_en,
    output logic [loader_pkg::REG_IDX_W-1:0]         reg_wr_idx,
    output logic [loader_pkg::DATA_W-1:0]            reg_wr_data,
    output logic [loader_pkg::REG_IDX_W-1:0]         reg_rd_idx,
    input  wire logic [loader_pkg::DATA_W-1:0]       reg_rd_data
);
    import loader_pkg::*;

    wr_state_e wr_state;
    rd_state_e rd_state;

    // write channel fsm
    // idle waits for address and data together, accept is the handshake cycle,
    // resp holds bvalid until the host takes it
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_state <= WR_IDLE;
        end
        else
        begin
            case (wr_state)
                WR_IDLE:
                begin
                    if (awvalid && wvalid)
                    begin
                        wr_state <= WR_ACCEPT;
                    end
                end
                WR_ACCEPT:
                begin
                    wr_state <= WR_RESP;
                end
                WR_RESP:
                begin
                    if (bready)
                    begin
                        wr_state <= WR_IDLE;
                    end
                end
                default:
                begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    // capture register index and data while the host holds them valid
    always_ff @(posedge clk)
    begin
        if (wr_state == WR_IDLE && awvalid && wvalid)
        begin
            reg_wr_idx  <= awaddr[BUS_ADDR_W-1:REG_ADDR_LSB];
            reg_wr_data <= wdata;
        end
    end

    // ready pair and register strobe share the accept cycle
    assign awready   = (wr_state == WR_ACCEPT);
    assign wready    = (wr_state == WR_ACCEPT);
    assign reg_wr_en = (wr_state == WR_ACCEPT);
    assign bvalid    = (wr_state == WR_RESP);
    // always okay, no error responses in this block
    assign bresp     = RESP_OKAY;

    // read channel fsm
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_state <= RD_IDLE;
        end
        else
        begin
            case (rd_state)
                RD_IDLE:
                begin
                    if (arvalid)
                    begin
                        rd_state <= RD_ACCEPT;
                    end
                end
                RD_ACCEPT:
                begin
                    rd_state <= RD_DATA;
                end
                RD_DATA:
                begin
                    if (rready)
                    begin
                        rd_state <= RD_IDLE;
                    end
                end
                default:
                begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    // latch the read index, the register mux sees it during accept
    always_ff @(posedge clk)
    begin
        if (rd_state == RD_IDLE && arvalid)
        begin
            reg_rd_idx <= araddr[BUS_ADDR_W-1:REG_ADDR_LSB];
        end
    end

    // data is sampled once and stays put while rvalid waits on rready
    always_ff @(posedge clk)
    begin
        if (rd_state == RD_ACCEPT)
        begin
            rdata <= reg_rd_data;
        end
    end

    assign arready = (rd_state == RD_ACCEPT);
    assign rvalid  = (rd_state == RD_DATA);
    assign rresp   = RESP_OKAY;

    // a response may only be withdrawn after the host took it
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid);
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

// ==== src/loader_regs.sv ====
// loader host register file
// storage with reset values, status read mux and push decode
`default_nettype none
`timescale 1ns/1ps

module loader_regs (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    // bus side strobes
    input  wire logic                                reg_wr_en,
    input  wire logic [loader_pkg::REG_IDX_W-1:0]    reg_wr_idx,
    input  wire logic [loader_pkg::DATA_W-1:0]       reg_wr_data,
    input  wire logic [loader_pkg::REG_IDX_W-1:0]    reg_rd_idx,
    output logic [loader_pkg::DATA_W-1:0]            reg_rd_data,
    // status from the datapath
    input  wire logic                                full,
    input  wire logic                                empty,
    input  wire logic [loader_pkg::DATA_W-1:0]       entry_cnt,
    input  wire logic [loader_pkg::WORD_CNT_W-1:0]   pop_cnt,
    // to the queue and the packer
    output logic                                     push,
    output logic [loader_pkg::DATA_W-1:0]            push_data,
    output logic [loader_pkg::DATA_W-1:0]            mem_addr_reg,
    output logic [loader_pkg::DATA_W-1:0]            prog_size
);
    import loader_pkg::*;

    logic [DATA_W-1:0] regs [REG_NUM];

    // program size starts at all ones so done stays low until it is set
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < REG_NUM; i++)
            begin
                if (i == REG_PROG_SIZE)
                begin
                    regs[i] <= '1;
                end
                else
                begin
                    regs[i] <= '0;
                end
            end
        end
        else if (reg_wr_en)
        begin
            regs[reg_wr_idx] <= reg_wr_data;
        end
    end

    // status slots hide whatever was stored there
    always_comb
    begin
        case (reg_rd_idx)
            REG_PUSH_FULL:
            begin
                reg_rd_data = {{(DATA_W-1){1'b0}}, full};
            end
            REG_ENTRY_CNT:
            begin
                reg_rd_data = entry_cnt;
            end
            REG_EMPTY:
            begin
                reg_rd_data = {{(DATA_W-1){1'b0}}, empty};
            end
            REG_POP_CNT:
            begin
                reg_rd_data = {{(DATA_W-WORD_CNT_W){1'b0}}, pop_cnt};
            end
            default:
            begin
                reg_rd_data = regs[reg_rd_idx];
            end
        endcase
    end

    // push follows the write strobe by one cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            push <= 1'b0;
        end
        else
        begin
            push <= reg_wr_en && (reg_wr_idx == REG_PUSH_FULL);
        end
    end

    // word payload, only meaningful while push is high
    always_ff @(posedge clk)
    begin
        push_data <= reg_wr_data;
    end

    assign mem_addr_reg = regs[REG_MEM_ADDR];
    assign prog_size    = regs[REG_PROG_SIZE];

endmodule

`default_nettype wire

// ==== src/push_fifo.sv ====
// word queue from the register write side to the entry packer
`default_nettype none
`timescale 1ns/1ps

module push_fifo (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                push,
    input  wire logic [loader_pkg::DATA_W-1:0]       push_data,
    input  wire logic                                pop,
    output logic                                     full,
    output logic                                     empty,
    output logic [loader_pkg::DATA_W-1:0]            head_data
);
    import loader_pkg::*;

    logic [DATA_W-1:0]     mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    // one extra bit so a full queue is distinct from an empty one
    logic [FIFO_PTR_W:0]   count;
    logic                  do_push;
    logic                  do_pop;

    // a push into a full queue is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave the count alone
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    assign full      = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));
    assign empty     = (count == '0);
    assign head_data = mem[rd_ptr];

    // the packer must only pop a word that is there
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

`default_nettype wire

// ==== src/entry_assembler.sv ====
// entry packer that builds memory entries from queued words
// pulses the memory write per entry, counts entries and raises done
`default_nettype none
`timescale 1ns/1ps

module entry_assembler (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                empty,
    input  wire logic [loader_pkg::DATA_W-1:0]       head_data,
    input  wire logic [loader_pkg::DATA_W-1:0]       prog_size,
    output logic                                     pop,
    output logic [loader_pkg::ENTRY_W-1:0]           memory_data,
    output logic                                     memory_we,
    output logic [loader_pkg::DATA_W-1:0]            entry_cnt,
    output logic [loader_pkg::WORD_CNT_W-1:0]        pop_cnt,
    output logic                                     done
);
    import loader_pkg::*;

    // partial entry of up to three words that enter at the low end
    logic [ENTRY_W-DATA_W-1:0] shift_data;
    logic                      last_word;

    // drain the queue as fast as it fills
    assign pop       = !empty;
    assign last_word = pop && (pop_cnt == WORD_CNT_W'(WORDS_PER_ENTRY-1));

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            shift_data <= {shift_data[ENTRY_W-2*DATA_W-1:0], head_data};
        end
        // finished entry is captured so it holds until the next strobe
        if (last_word)
        begin
            memory_data <= {shift_data, head_data};
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pop_cnt   <= '0;
            memory_we <= 1'b0;
            entry_cnt <= '0;
        end
        else
        begin
            // wrap after the last word of an entry
            if (last_word)
            begin
                pop_cnt <= '0;
            end
            else if (pop)
            begin
                pop_cnt <= pop_cnt + 1'b1;
            end
            memory_we <= last_word;
            if (last_word)
            begin
                entry_cnt <= entry_cnt + 1'b1;
            end
        end
    end

    // sticky until reset
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            done <= 1'b0;
        end
        else if (entry_cnt >= prog_size)
        begin
            done <= 1'b1;
        end
    end

    // four pops per entry so strobes are never adjacent
    a_we_single: assert property (@(posedge clk) disable iff (!rst_n)
        memory_we |=> !memory_we);

endmodule

`default_nettype wire

// ==== src/program_loader_top.sv ====
// program loader top level
// axi4-lite host registers feeding a word queue and a memory entry packer
`default_nettype none
`timescale 1ns/1ps

module program_loader_top (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    // axi4-lite slave port
    input  wire logic [loader_pkg::BUS_ADDR_W-1:0]   awaddr,
    input  wire logic                                awvalid,
    output logic                                     awready,
    input  wire logic [loader_pkg::DATA_W-1:0]       wdata,
    input  wire logic                                wvalid,
    output logic                                     wready,
    output logic                                     bvalid,
    output logic [1:0]                               bresp,
    input  wire logic                                bready,
    input  wire logic [loader_pkg::BUS_ADDR_W-1:0]   araddr,
    input  wire logic                                arvalid,
    output logic                                     arready,
    output logic                                     rvalid,
    output logic [loader_pkg::DATA_W-1:0]            rdata,
    output logic [1:0]                               rresp,
    input  wire logic                                rready,
    // program memory write port
    output logic [loader_pkg::MEM_ADDR_W-1:0]        memory_addr,
    output logic [loader_pkg::ENTRY_W-1:0]           memory_data,
    output logic                                     memory_we,
    output logic                                     done
);
    import loader_pkg::*;

    // register strobes
    logic                  reg_wr_en;
    logic [REG_IDX_W-1:0]  reg_wr_idx;
    logic [DATA_W-1:0]     reg_wr_data;
    logic [REG_IDX_W-1:0]  reg_rd_idx;
    logic [DATA_W-1:0]     reg_rd_data;
    // queue and packer
    logic                  push;
    logic [DATA_W-1:0]     push_data;
    logic                  pop;
    logic                  full;
    logic                  empty;
    logic [DATA_W-1:0]     head_data;
    logic [DATA_W-1:0]     mem_addr_reg;
    logic [DATA_W-1:0]     prog_size;
    logic [DATA_W-1:0]     entry_cnt;
    logic [WORD_CNT_W-1:0] pop_cnt;

    axil_slave_ctrl axil_slave_ctrl_i (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bvalid, .bresp, .bready,
        .araddr, .arvalid, .arready, .rvalid, .rdata, .rresp, .rready,
        .reg_wr_en, .reg_wr_idx, .reg_wr_data, .reg_rd_idx, .reg_rd_data
    );

    loader_regs loader_regs_i (
        .clk, .rst_n,
        .reg_wr_en, .reg_wr_idx, .reg_wr_data, .reg_rd_idx, .reg_rd_data,
        .full, .empty, .entry_cnt, .pop_cnt,
        .push, .push_data, .mem_addr_reg, .prog_size
    );

    push_fifo push_fifo_i (
        .clk, .rst_n, .push, .push_data, .pop, .full, .empty, .head_data
    );

    entry_assembler entry_assembler_i (
        .clk, .rst_n, .empty, .head_data, .prog_size,
        .pop, .memory_data, .memory_we, .entry_cnt, .pop_cnt, .done
    );

    // memory sees only the low address bits
    assign memory_addr = mem_addr_reg[MEM_ADDR_W-1:0];

endmodule

`default_nettype wire

// ==== verification/program_loader_tb.sv ====
// program loader testbench
// replays host commands from a data file, checks register reads and memory writes
`default_nettype none
`timescale 1ns/1ps

module program_loader_tb;
    import loader_pkg::*;

    // watchdog budget and strobe wait limit, in clock cycles
    localparam int CYCLES_PER_CMD = 200;
    localparam int STROBE_WAIT    = 100;

    logic                  clk;
    logic                  rst_n;
    logic [BUS_ADDR_W-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [DATA_W-1:0]     wdata;
    logic                  wvalid;
    logic                  wready;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  bready;
    logic [BUS_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic                  rvalid;
    logic [DATA_W-1:0]     rdata;
    logic [1:0]            rresp;
    logic                  rready;
    logic [MEM_ADDR_W-1:0] memory_addr;
    logic [ENTRY_W-1:0]    memory_data;
    logic                  memory_we;
    logic                  done;

    // memory writes seen on the port, consumed by entry checks
    logic [MEM_ADDR_W-1:0] seen_addr [$];
    logic [ENTRY_W-1:0]    seen_data [$];
    // command lines of the data file, comments and blanks removed
    string                 cmd_lines [$];
    int                    cmd_total;
    int                    test_errs;
    int                    err_total;
    int                    test_num;
    int                    tests_failed;
    logic [31:0]           lcg_state;

    program_loader_top program_loader_top_i (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bvalid, .bresp, .bready,
        .araddr, .arvalid, .arready, .rvalid, .rdata, .rresp, .rready,
        .memory_addr, .memory_data, .memory_we, .done
    );

    // 10 ns clock
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    // strobe is one cycle wide, sampled mid-cycle
    always @(negedge clk)
    begin
        if (rst_n && memory_we === 1'b1)
        begin
            seen_addr.push_back(memory_addr);
            seen_data.push_back(memory_data);
        end
    end

    // ready delay of 0..3 cycles from an lcg
    function automatic int unsigned next_delay();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 16) % 4;
    endfunction

    function automatic string strip_eol(input string s);
        string r;
        r = s;
        while (r.len() > 0 && (r.getc(r.len() - 1) == 8'd10 || r.getc(r.len() - 1) == 8'd13))
        begin
            r = r.substr(0, r.len() - 2);
        end
        return r;
    endfunction

    task automatic check_value(input logic [ENTRY_W-1:0] got, input logic [ENTRY_W-1:0] exp,
                               input string what);
        if (got !== exp)
        begin
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    // one write transfer, response taken after a random delay
    task automatic bus_write(input logic [REG_IDX_W-1:0] idx, input logic [DATA_W-1:0] data);
        int unsigned delay;
        delay = next_delay();
        @(posedge clk);
        awaddr  <= BUS_ADDR_W'(idx) << REG_ADDR_LSB;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!(awready && wready))
        begin
            @(negedge clk);
        end
        // handshake completes on this edge
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat (delay)
        begin
            @(posedge clk);
        end
        bready <= 1'b1;
        @(negedge clk);
        while (!bvalid)
        begin
            @(negedge clk);
        end
        check_value(bresp, RESP_OKAY, "bresp");
        @(posedge clk);
        bready <= 1'b0;
    endtask

    // one read transfer, data taken after a random delay
    task automatic bus_read(input logic [REG_IDX_W-1:0] idx, output logic [DATA_W-1:0] data);
        int unsigned delay;
        delay = next_delay();
        @(posedge clk);
        araddr  <= BUS_ADDR_W'(idx) << REG_ADDR_LSB;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        repeat (delay)
        begin
            @(posedge clk);
        end
        rready <= 1'b1;
        @(negedge clk);
        while (!rvalid)
        begin
            @(negedge clk);
        end
        data = rdata;
        check_value(rresp, RESP_OKAY, "rresp");
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // polled on the rising edge so the negedge monitor has already run
    task automatic expect_entry(input logic [MEM_ADDR_W-1:0] addr,
                                input logic [ENTRY_W-1:0] data);
        int waited;
        waited = 0;
        while (seen_addr.size() == 0 && waited < STROBE_WAIT)
        begin
            @(posedge clk);
            waited++;
        end
        if (seen_addr.size() == 0)
        begin
            $display("no memory write strobe came within %0d cycles (time %0t)",
                     STROBE_WAIT, $time);
            test_errs++;
        end
        else
        begin
            check_value(seen_addr.pop_front(), addr, "memory_addr");
            check_value(seen_data.pop_front(), data, "memory_data");
        end
    endtask

    // done follows the entry count by one cycle
    task automatic expect_done(input logic exp);
        repeat (2)
        begin
            @(negedge clk);
        end
        check_value(done, exp, "done");
    endtask

    task automatic finish_test(input string name);
        if (seen_addr.size() != 0)
        begin
            $display("%0d memory write strobes came that no entry check expected",
                     seen_addr.size());
            test_errs += seen_addr.size();
            seen_addr.delete();
            seen_data.delete();
        end
        test_num++;
        if (test_errs == 0)
        begin
            $display("test %0d %s: ok", test_num, name);
        end
        else
        begin
            $display("test %0d %s: %0d errors", test_num, name, test_errs);
            tests_failed++;
        end
        err_total += test_errs;
        test_errs = 0;
    endtask

    // watchdog sized from the command count
    initial
    begin
        wait (cmd_total > 0);
        repeat (cmd_total * CYCLES_PER_CMD)
        begin
            @(posedge clk);
        end
        $display("timeout, the run did not end within %0d cycles", cmd_total * CYCLES_PER_CMD);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        int                 fd;
        int                 n;
        string              line;
        logic [7:0]         cmd;
        logic [31:0]        op_a;
        logic [ENTRY_W-1:0] op_b;
        logic [DATA_W-1:0]  rd;

        rst_n     = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        lcg_state = 32'hebca;

        fd = $fopen("verification/loader_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the test data file");
            $display("** FAIL **");
            $finish;
        end
        else
        begin
            // keep only command lines
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                line = strip_eol(line);
                if (n > 0 && line.len() > 0 && line.getc(0) != "#")
                begin
                    cmd_lines.push_back(line);
                end
            end
            $fclose(fd);
            cmd_total = cmd_lines.size();

            repeat (5)
            begin
                @(posedge clk);
            end
            rst_n <= 1'b1;

            foreach (cmd_lines[i])
            begin
                op_a = '0;
                op_b = '0;
                n = $sscanf(cmd_lines[i], "%c %h %h", cmd, op_a, op_b);
                case (cmd)
                    "W":
                    begin
                        bus_write(op_a[REG_IDX_W-1:0], op_b[DATA_W-1:0]);
                    end
                    "R":
                    begin
                        bus_read(op_a[REG_IDX_W-1:0], rd);
                        check_value(rd, op_b, $sformatf("register %0d", op_a));
                    end
                    "E":
                    begin
                        expect_entry(op_a[MEM_ADDR_W-1:0], op_b);
                    end
                    "D":
                    begin
                        expect_done(op_a[0]);
                    end
                    "T":
                    begin
                        finish_test(cmd_lines[i].substr(2, cmd_lines[i].len() - 1));
                    end
                    default:
                    begin
                        $display("unknown command in data file line: %s", cmd_lines[i]);
                        test_errs++;
                    end
                endcase
            end

            // errors after the last test line still count
            err_total += test_errs;
            $display("tests run: %0d, tests failed: %0d, errors: %0d",
                     test_num, tests_failed, err_total);
            if (tests_failed == 0 && err_total == 0)
            begin
                $display("** PASS **");
            end
            else
            begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
src/loader_pkg.sv
src/axil_slave_ctrl.sv
src/loader_regs.sv
src/push_fifo.sv
src/entry_assembler.sv
src/program_loader_top.sv
verification/program_loader_tb.sv

// ==== verification/loader_testdata.txt ====
# loader commands, hex operands: W idx data | R idx expected | E addr entry
# D done | T test name (closes a test)
R 2 ffffffff
R 4 00000001
R 0 00000000
R 3 00000000
D 0
T reset_values
W 1 00001a40
R 1 00001a40
W 6 cafe0006
W 7 0badf00d
R 6 cafe0006
R 7 0badf00d
T register_readback
W 2 00000002
R 2 00000002
W 0 11111111
W 0 22222222
W 0 33333333
W 0 44444444
E 1a40 11111111222222223333333344444444
D 0
W 1 00052000
W 0 a0000001
W 0 a0000002
W 0 a0000003
W 0 a0000004
E 2000 a0000001a0000002a0000003a0000004
D 1
R 3 00000002
T program_size_done
W 1 00000100
W 0 55555555
W 0 66666666
W 0 77777777
R 5 00000003
R 4 00000001
T partial_entry
W 0 88888888
E 0100 55555555666666667777777788888888
R 5 00000000
R 3 00000003
T entry_complete
W 6 12345678
R 6 12345678
W 0 9999aaaa
R 5 00000001
R 4 00000001
W 0 9999bbbb
W 0 9999cccc
W 0 9999dddd
E 0100 9999aaaa9999bbbb9999cccc9999dddd
R 3 00000004
R 5 00000000
D 1
T held_response
